//--- source/excUnit_defines.svh
`ifndef EXC_UNIT_DEFINES_SVH
`define EXC_UNIT_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// bus address map
////////////////////////////////////////////////////////////////////////////

`define EXC_ADDR_WIDTH 16

`define TIMER0_BASE 16'h7F00
`define TIMER1_BASE 16'h7F10

`define TIMER_CTRL_OFF   4'h0
`define TIMER_PRESET_OFF 4'h4
`define TIMER_COUNT_OFF  4'h8

////////////////////////////////////////////////////////////////////////////
// coprocessor-0 constants and field positions
////////////////////////////////////////////////////////////////////////////

`define PRID_VALUE 32'h0000_1E01

`define SR_IE    0
`define SR_EXL   1
`define SR_IM_HI 15
`define SR_IM_LO 10

`define CAUSE_EXC_HI 6
`define CAUSE_EXC_LO 2
`define CAUSE_IP_HI  15
`define CAUSE_IP_LO  10
`define CAUSE_BD     31

`endif

//--- source/excPkg.sv
`default_nettype none

package excPkg;

    // exception codes as written to Cause.ExcCode
    typedef enum logic [4:0] {
        excInt     = 5'd0,
        excAdEL    = 5'd4,
        excAdES    = 5'd5,
        excSyscall = 5'd8,
        excRI      = 5'd10,
        excOv      = 5'd12,
        excNone    = 5'd31  // internal only, never recorded
    } excCode;

    typedef enum logic [4:0] {
        regSR    = 5'd12,
        regCause = 5'd13,
        regEPC   = 5'd14,
        regPRId  = 5'd15
    } cp0RegNum;

    typedef enum logic [1:0] {
        modeOneShot    = 2'd0,
        modeAutoReload = 2'd1
    } timerMode;

    typedef enum logic [1:0] {
        stIdle,
        stLoad,
        stCount,
        stDone
    } timerState;

    typedef enum logic [1:0] {
        respOkay   = 2'd0,
        respSlvErr = 2'd2,
        respDecErr = 2'd3
    } axiResp;

endpackage

`default_nettype wire

//--- source/excPriority.sv
`default_nettype none

module excPriority (
    input  logic          fetchAddrErr,
    input  logic          reservedInstr,
    input  logic          syscall,
    input  logic          overflow,
    input  logic          loadAddrErr,
    input  logic          storeAddrErr,
    output excPkg::excCode excCodeSel
);

    import excPkg::*;

    // earlier pipeline stages win, so the scan order follows the pipe
    always_comb begin
        if (fetchAddrErr) begin
            excCodeSel = excAdEL;       // bad fetch address
        end else if (reservedInstr) begin
            excCodeSel = excRI;
        end else if (syscall) begin
            excCodeSel = excSyscall;
        end else if (overflow) begin
            excCodeSel = excOv;         // arithmetic overflow in execute
        end else if (loadAddrErr) begin
            excCodeSel = excAdEL;       // misaligned or bad load
        end else if (storeAddrErr) begin
            excCodeSel = excAdES;
        end else begin
            excCodeSel = excNone;
        end
    end

endmodule

`default_nettype wire

//--- source/cp0Regs.sv
`default_nettype none

`include "excUnit_defines.svh"

module cp0Regs (
    input  logic              clk,
    input  logic              reset,
    input  logic              cp0WrEn,
    input  logic              eret,
    input  logic              inDelaySlot,
    input  excPkg::cp0RegNum  cp0Addr,
    input  logic [31:0]       cp0WrData,
    input  logic [31:0]       victimPc,
    input  excPkg::excCode    excCodeSel,
    input  logic [5:0]        hwInt,
    output logic [31:0]       cp0RdData,
    output logic [31:0]       epc,
    output logic              excReq
);

    import excPkg::*;

    logic [31:0] sr;
    logic [31:0] cause;
    logic        intReq;
    logic        excEvent;
    logic        exl;

    assign exl = sr[`SR_EXL];

    ////////////////////////////////////////////////////////////////////////////
    // request logic
    ////////////////////////////////////////////////////////////////////////////

    // interrupt needs global enable, a matching mask bit and no handler running
    assign intReq   = sr[`SR_IE] & ~exl & (|(hwInt & sr[`SR_IM_HI:`SR_IM_LO]));
    assign excEvent = (excCodeSel != excNone) & ~exl;
    assign excReq   = intReq | excEvent;

    ////////////////////////////////////////////////////////////////////////////
    // register updates
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sr    <= 32'b0;
            cause <= 32'b0;
            epc   <= 32'b0;
        end else begin
            cause[`CAUSE_IP_HI:`CAUSE_IP_LO] <= hwInt;  // pending lines, every cycle
            if (excReq) begin
                // a delay-slot victim restarts at its branch
                epc <= inDelaySlot ? victimPc - 32'd4 : victimPc;
                cause[`CAUSE_BD] <= inDelaySlot;
                // interrupt beats a simultaneous exception
                cause[`CAUSE_EXC_HI:`CAUSE_EXC_LO] <= intReq ? excInt : excCodeSel;
                sr[`SR_EXL] <= 1'b1;
            end else if (eret) begin
                sr[`SR_EXL] <= 1'b0;            // back to user flow
            end else if (cp0WrEn) begin
                case (cp0Addr)
                    regSR:   sr  <= cp0WrData;
                    regEPC:  epc <= cp0WrData;
                    default: ;                  // Cause and PRId are read-only
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (cp0Addr)
            regSR:    cp0RdData = sr;
            regCause: cp0RdData = cause;
            regEPC:   cp0RdData = epc;
            regPRId:  cp0RdData = `PRID_VALUE;
            default:  cp0RdData = 32'b0;        // unimplemented register
        endcase
    end

endmodule

`default_nettype wire

//--- source/intervalTimer.sv
`default_nettype none

`include "excUnit_defines.svh"

module intervalTimer (
    input  logic        clk,
    input  logic        reset,
    input  logic        regWrEn,
    input  logic        regRdEn,
    input  logic [3:0]  regOffset,
    input  logic [31:0] regWrData,
    output logic [31:0] regRdData,
    output logic        irq
);

    import excPkg::*;

    logic        enable;        // ctrl bit 0
    timerMode    mode;          // ctrl bits 2:1
    logic        irqMask;       // ctrl bit 3
    logic [31:0] preset;
    logic [31:0] count;
    logic        oneShotIrq;    // sticky flag after a one-shot expiry
    timerState   state;
    logic        ctrlWr;

    assign ctrlWr = regWrEn && (regOffset == `TIMER_CTRL_OFF);

    always_ff @(posedge clk) begin
        if (reset) begin
            enable     <= 1'b0;
            mode       <= modeOneShot;
            irqMask    <= 1'b0;
            preset     <= 32'b0;
            count      <= 32'b0;
            oneShotIrq <= 1'b0;
            state      <= stIdle;
        end else begin
            case (state)
                stIdle: ;
                stLoad: begin
                    count <= preset;
                    state <= stCount;
                end
                stCount: begin
                    if (count == 32'b0) begin
                        state <= stDone;
                    end else begin
                        count <= count - 32'd1;
                    end
                end
                stDone: begin
                    if (mode == modeAutoReload) begin
                        count <= preset;        // reload and keep going
                        state <= stCount;
                    end else begin
                        enable     <= 1'b0;
                        oneShotIrq <= 1'b1;
                        state      <= stIdle;
                    end
                end
            endcase

            // a ctrl write restarts or stops the timer
            if (ctrlWr) begin
                enable     <= regWrData[0];
                mode       <= timerMode'(regWrData[2:1]);
                irqMask    <= regWrData[3];
                oneShotIrq <= 1'b0;
                state      <= regWrData[0] ? stLoad : stIdle;
            end
            if (regWrEn && (regOffset == `TIMER_PRESET_OFF)) begin
                preset <= regWrData;
            end
        end
    end

    assign irq = irqMask & ((state == stDone) | oneShotIrq);

    always_comb begin
        regRdData = 32'b0;
        if (regRdEn) begin
            case (regOffset)
                `TIMER_CTRL_OFF:   regRdData = {28'b0, irqMask, mode, enable};
                `TIMER_PRESET_OFF: regRdData = preset;
                `TIMER_COUNT_OFF:  regRdData = count;
                default:           regRdData = 32'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/timerBus.sv
`default_nettype none

`include "excUnit_defines.svh"

module timerBus (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       awvalid,
    input  logic                       wvalid,
    input  logic                       bready,
    input  logic                       arvalid,
    input  logic                       rready,
    input  logic [`EXC_ADDR_WIDTH-1:0] awaddr,
    input  logic [`EXC_ADDR_WIDTH-1:0] araddr,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    output logic                       awready,
    output logic                       wready,
    output logic                       bvalid,
    output logic                       arready,
    output logic                       rvalid,
    output excPkg::axiResp             bresp,
    output excPkg::axiResp             rresp,
    output logic [31:0]                rdata,
    output logic                       t0RegWrEn,
    output logic                       t0RegRdEn,
    output logic [3:0]                 t0RegOffset,
    output logic [31:0]                t0RegWrData,
    input  logic [31:0]                t0RegRdData,
    output logic                       t1RegWrEn,
    output logic                       t1RegRdEn,
    output logic [3:0]                 t1RegOffset,
    output logic [31:0]                t1RegWrData,
    input  logic [31:0]                t1RegRdData
);

    import excPkg::*;

    typedef enum logic [2:0] {
        busIdle,
        busWrAck,
        busWrResp,
        busRdAck,
        busRdResp
    } busState;

    localparam logic [`EXC_ADDR_WIDTH-1:0] timer0Base = `TIMER0_BASE;
    localparam logic [`EXC_ADDR_WIDTH-1:0] timer1Base = `TIMER1_BASE;

    busState state;
    logic    wrHit0, wrHit1, wrOffOk, wrOk;
    logic    rdHit0, rdHit1, rdOffOk;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    assign wrHit0  = awaddr[`EXC_ADDR_WIDTH-1:4] == timer0Base[`EXC_ADDR_WIDTH-1:4];
    assign wrHit1  = awaddr[`EXC_ADDR_WIDTH-1:4] == timer1Base[`EXC_ADDR_WIDTH-1:4];
    assign rdHit0  = araddr[`EXC_ADDR_WIDTH-1:4] == timer0Base[`EXC_ADDR_WIDTH-1:4];
    assign rdHit1  = araddr[`EXC_ADDR_WIDTH-1:4] == timer1Base[`EXC_ADDR_WIDTH-1:4];
    assign wrOffOk = awaddr[3:0] inside {`TIMER_CTRL_OFF, `TIMER_PRESET_OFF, `TIMER_COUNT_OFF};
    assign rdOffOk = araddr[3:0] inside {`TIMER_CTRL_OFF, `TIMER_PRESET_OFF, `TIMER_COUNT_OFF};
    assign wrOk    = wrOffOk && (&wstrb);   // full words only

    ////////////////////////////////////////////////////////////////////////////
    // transaction FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= busIdle;
            bresp <= respOkay;
            rresp <= respOkay;
        end else begin
            case (state)
                busIdle: begin
                    if (awvalid && wvalid) begin
                        state <= busWrAck;      // writes go first
                    end else if (arvalid) begin
                        state <= busRdAck;
                    end
                end
                busWrAck: begin
                    state <= busWrResp;
                    if (!(wrHit0 || wrHit1) || !wrOffOk) begin
                        bresp <= respDecErr;
                    end else if (!(&wstrb)) begin
                        bresp <= respSlvErr;
                    end else begin
                        bresp <= respOkay;
                    end
                end
                busWrResp: if (bready) state <= busIdle;
                busRdAck: begin
                    state <= busRdResp;
                    rresp <= ((rdHit0 || rdHit1) && rdOffOk) ? respOkay : respDecErr;
                end
                busRdResp: if (rready) state <= busIdle;
                default: state <= busIdle;
            endcase
        end
    end

    // held until rready, so rdata stays put
    always_ff @(posedge clk) begin
        if (state == busRdAck) begin
            rdata <= t0RegRdEn ? t0RegRdData : t1RegRdEn ? t1RegRdData : 32'b0;
        end
    end

    assign awready = state == busWrAck;
    assign wready  = state == busWrAck;
    assign bvalid  = state == busWrResp;
    assign arready = state == busRdAck;
    assign rvalid  = state == busRdResp;

    // register strobes to the timers
    assign t0RegWrEn   = (state == busWrAck) && wrHit0 && wrOk;
    assign t1RegWrEn   = (state == busWrAck) && wrHit1 && wrOk;
    assign t0RegRdEn   = (state == busRdAck) && rdHit0 && rdOffOk;
    assign t1RegRdEn   = (state == busRdAck) && rdHit1 && rdOffOk;
    assign t0RegOffset = (state == busRdAck) ? araddr[3:0] : awaddr[3:0];
    assign t1RegOffset = (state == busRdAck) ? araddr[3:0] : awaddr[3:0];
    assign t0RegWrData = wdata;
    assign t1RegWrData = wdata;

endmodule

`default_nettype wire

//--- source/excUnit.sv
`default_nettype none

`include "excUnit_defines.svh"

module excUnit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fetchAddrErr,
    input  logic                       reservedInstr,
    input  logic                       syscall,
    input  logic                       overflow,
    input  logic                       loadAddrErr,
    input  logic                       storeAddrErr,
    input  logic [31:0]                victimPc,
    input  logic                       inDelaySlot,
    input  excPkg::cp0RegNum           cp0Addr,
    input  logic [31:0]                cp0WrData,
    input  logic                       cp0WrEn,
    input  logic                       eret,
    output logic [31:0]                cp0RdData,
    output logic [31:0]                epc,
    output logic                       excReq,
    input  logic [3:0]                 extInt,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`EXC_ADDR_WIDTH-1:0] awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    output logic                       bvalid,
    input  logic                       bready,
    output excPkg::axiResp             bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`EXC_ADDR_WIDTH-1:0] araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [31:0]                rdata,
    output excPkg::axiResp             rresp
);

    import excPkg::*;

    excCode      excCodeSel;
    logic        irq0, irq1;
    logic        t0WrEn, t0RdEn, t1WrEn, t1RdEn;
    logic [3:0]  t0Offset, t1Offset;
    logic [31:0] t0WrData, t0RdData, t1WrData, t1RdData;

    excPriority prio0 (
        .fetchAddrErr(fetchAddrErr), .reservedInstr(reservedInstr), .syscall(syscall),
        .overflow(overflow), .loadAddrErr(loadAddrErr), .storeAddrErr(storeAddrErr),
        .excCodeSel(excCodeSel)
    );

    // timers on lines 0 and 1, external pins above them
    cp0Regs cp0 (
        .clk(clk), .reset(reset), .cp0WrEn(cp0WrEn), .eret(eret),
        .inDelaySlot(inDelaySlot), .cp0Addr(cp0Addr), .cp0WrData(cp0WrData),
        .victimPc(victimPc), .excCodeSel(excCodeSel), .hwInt({extInt, irq1, irq0}),
        .cp0RdData(cp0RdData), .epc(epc), .excReq(excReq)
    );

    timerBus bus0 (
        .clk(clk), .reset(reset), .awvalid(awvalid), .wvalid(wvalid), .bready(bready),
        .arvalid(arvalid), .rready(rready), .awaddr(awaddr), .araddr(araddr),
        .wdata(wdata), .wstrb(wstrb), .awready(awready), .wready(wready),
        .bvalid(bvalid), .arready(arready), .rvalid(rvalid), .bresp(bresp),
        .rresp(rresp), .rdata(rdata),
        .t0RegWrEn(t0WrEn), .t0RegRdEn(t0RdEn), .t0RegOffset(t0Offset),
        .t0RegWrData(t0WrData), .t0RegRdData(t0RdData),
        .t1RegWrEn(t1WrEn), .t1RegRdEn(t1RdEn), .t1RegOffset(t1Offset),
        .t1RegWrData(t1WrData), .t1RegRdData(t1RdData)
    );

    intervalTimer timer0 (
        .clk(clk), .reset(reset), .regWrEn(t0WrEn), .regRdEn(t0RdEn),
        .regOffset(t0Offset), .regWrData(t0WrData), .regRdData(t0RdData), .irq(irq0)
    );

    intervalTimer timer1 (
        .clk(clk), .reset(reset), .regWrEn(t1WrEn), .regRdEn(t1RdEn),
        .regOffset(t1Offset), .regWrData(t1WrData), .regRdData(t1RdData), .irq(irq1)
    );

endmodule

`default_nettype wire

//--- tb/excUnit_properties.sv
`default_nettype none

module excUnit_properties (
    input logic                clk,
    input logic                reset,
    input logic                bvalid,
    input logic                bready,
    input excPkg::axiResp      bresp,
    input logic                rvalid,
    input logic                rready,
    input logic [31:0]         rdata,
    input logic                excReq,
    input logic                exl
);

    timeunit 1ns;
    timeprecision 100ps;

    // a write response stays up until the master takes it
    bHold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

    rHold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

    bStable: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> $stable(bresp)) else $error("bresp changed while bvalid held");

    rStable: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> $stable(rdata)) else $error("rdata changed while rvalid held");

    // a taken request enters the handler on the next edge
    exlOnReq: assert property (@(posedge clk) disable iff (reset)
        excReq |=> exl) else $error("EXL not set after excReq");

endmodule

`default_nettype wire

//--- tb/excUnit_tb.sv
`default_nettype none

`include "excUnit_defines.svh"

module excUnit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import excPkg::*;

    localparam int cycleLimit = 4000;   // six tests of ~300 cycles, doubled

    logic        clk = 1'b0;
    logic        reset;
    logic        fetchAddrErr, reservedInstr, syscall, overflow, loadAddrErr, storeAddrErr;
    logic [31:0] victimPc;
    logic        inDelaySlot;
    cp0RegNum    cp0Addr;
    logic [31:0] cp0WrData;
    logic        cp0WrEn;
    logic        eret;
    logic [31:0] cp0RdData;
    logic [31:0] epc;
    logic        excReq;
    logic [3:0]  extInt;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [15:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    axiResp      bresp, rresp;

    integer      seed = 32'hb817_4c55;
    int          cycles = 0;
    int          errorCount = 0;

    excUnit dut0 (.*);

    bind excUnit excUnit_properties props0 (
        .clk(clk), .reset(reset), .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .excReq(excReq),
        .exl(cp0.exl)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            reportFailure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic reportFailure(input string what);
        errorCount = errorCount + 1;
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Error in %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic checkResp(input string name, input axiResp expected, input axiResp actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Error in %s: expected %s, actual %s (%0d)",
                                    name, expected.name(), actual.name(), actual));
        end
    endtask

    task automatic checkCode(input string name, input excCode expected, input excCode actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Error in %s: expected %s, actual %s (%0d)",
                                    name, expected.name(), actual.name(), actual));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // pipeline and bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic setFlags(input logic [5:0] flags);
        {fetchAddrErr, reservedInstr, syscall, overflow, loadAddrErr, storeAddrErr} = flags;
    endtask

    task automatic cp0Write(input cp0RegNum addr, input logic [31:0] data);
        @(negedge clk);
        cp0Addr   = addr;
        cp0WrData = data;
        cp0WrEn   = 1'b1;
        @(negedge clk);
        cp0WrEn   = 1'b0;
    endtask

    task automatic cp0Read(input cp0RegNum addr, output logic [31:0] data);
        @(negedge clk);
        cp0Addr = addr;
        #1;                                 // let the read mux settle
        data = cp0RdData;
    endtask

    task automatic pulseEret();
        @(negedge clk);
        eret = 1'b1;
        @(negedge clk);
        eret = 1'b0;
    endtask

    task automatic axiWrite(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axiResp resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);                     // handshake taken on the edge before
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        @(negedge clk);                     // response held back one cycle
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready  = 1'b0;
    endtask

    task automatic axiRead(input logic [15:0] addr, output logic [31:0] data,
                           output axiResp resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        @(negedge clk);                     // response held back one cycle
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testCp0Regs();
        logic [31:0] word;
        logic [31:0] value;
        checkWord("reset outputs", 32'd0,
                  {26'd0, excReq, awready, wready, bvalid, arready, rvalid});
        cp0Read(regSR, word);
        checkWord("reset SR", 32'd0, word);
        cp0Read(regCause, word);
        checkWord("reset Cause", 32'd0, word);
        cp0Read(regEPC, word);
        checkWord("reset EPC", 32'd0, word);
        cp0Read(regPRId, word);
        checkWord("reset PRId", `PRID_VALUE, word);
        cp0Write(regSR, 32'h1234_5678);     // IE and EXL stay clear
        cp0Read(regSR, word);
        checkWord("SR write", 32'h1234_5678, word);
        value = $random(seed);
        cp0Write(regEPC, value);
        cp0Read(regEPC, word);
        checkWord("EPC write", value, word);
        cp0Write(regCause, 32'hFFFF_FFFF);
        cp0Read(regCause, word);
        checkWord("Cause read-only", 32'd0, word);
        cp0Write(regPRId, 32'd0);
        cp0Read(regPRId, word);
        checkWord("PRId read-only", `PRID_VALUE, word);
        cp0Write(regSR, 32'd0);
    endtask

    task automatic takeException(input string name, input logic [5:0] flags,
                                 input excCode expected, input logic delaySlot);
        logic [31:0] pc;
        logic [31:0] word;
        pc = $random(seed) & 32'hFFFF_FFFC;
        @(negedge clk);
        setFlags(flags);
        victimPc    = pc;
        inDelaySlot = delaySlot;
        #1;
        checkWord({name, " excReq"}, 32'd1, {31'd0, excReq});
        @(negedge clk);
        setFlags(6'b0);
        inDelaySlot = 1'b0;
        cp0Read(regCause, word);
        checkCode(name, expected, excCode'(word[`CAUSE_EXC_HI:`CAUSE_EXC_LO]));
        checkWord({name, " BD"}, {31'd0, delaySlot}, {31'd0, word[`CAUSE_BD]});
        cp0Read(regEPC, word);
        checkWord({name, " EPC"}, delaySlot ? pc - 32'd4 : pc, word);
        checkWord({name, " epc port"}, delaySlot ? pc - 32'd4 : pc, epc);
        // a syscall while the handler runs is ignored
        @(negedge clk);
        setFlags(6'b001000);
        #1;
        checkWord({name, " blocked by EXL"}, 32'd0, {31'd0, excReq});
        @(negedge clk);
        setFlags(6'b0);
        cp0Read(regCause, word);
        checkCode({name, " kept"}, expected, excCode'(word[`CAUSE_EXC_HI:`CAUSE_EXC_LO]));
        pulseEret();
        cp0Read(regSR, word);
        checkWord({name, " EXL after eret"}, 32'd0, {31'd0, word[`SR_EXL]});
    endtask

    task automatic testExceptions();
        // flag order: fetch, reserved, syscall, overflow, load, store
        takeException("priority fetch", 6'b101010, excAdEL, 1'b0);
        takeException("priority reserved", 6'b010101, excRI, 1'b1);
        takeException("priority syscall", 6'b001100, excSyscall, 1'b0);
        takeException("priority overflow", 6'b000111, excOv, 1'b1);
        takeException("priority load", 6'b000011, excAdEL, 1'b0);
        takeException("priority store", 6'b000001, excAdES, 1'b1);
    endtask

    task automatic testInterrupts();
        logic [31:0] word;
        cp0Write(regSR, 32'h0000_1001);     // IE plus mask for extInt[0]
        @(negedge clk);
        extInt   = 4'b0001;
        overflow = 1'b1;                    // same-cycle exception loses
        #1;
        checkWord("interrupt excReq", 32'd1, {31'd0, excReq});
        @(negedge clk);
        overflow = 1'b0;
        cp0Read(regCause, word);
        checkCode("interrupt code", excInt, excCode'(word[`CAUSE_EXC_HI:`CAUSE_EXC_LO]));
        checkWord("interrupt IP", 32'h4, {26'd0, word[`CAUSE_IP_HI:`CAUSE_IP_LO]});
        cp0Write(regSR, 32'h0000_0001);     // mask cleared, EXL cleared
        #1;
        checkWord("masked line", 32'd0, {31'd0, excReq});
        cp0Write(regSR, 32'h0000_1000);     // global enable cleared
        #1;
        checkWord("IE clear", 32'd0, {31'd0, excReq});
        @(negedge clk);
        extInt = 4'b0000;
        cp0Write(regSR, 32'd0);
    endtask

    task automatic testTimerBus();
        logic [31:0] value;
        logic [31:0] word;
        axiResp      resp;
        value = $random(seed);
        axiWrite(`TIMER0_BASE + `TIMER_PRESET_OFF, value, 4'hF, resp);
        checkResp("preset write", respOkay, resp);
        axiRead(`TIMER0_BASE + `TIMER_PRESET_OFF, word, resp);
        checkResp("preset read", respOkay, resp);
        checkWord("preset read", value, word);
        axiWrite(`TIMER1_BASE + `TIMER_CTRL_OFF, 32'hA, 4'hF, resp);   // not enabled
        checkResp("ctrl write", respOkay, resp);
        axiRead(`TIMER1_BASE + `TIMER_CTRL_OFF, word, resp);
        checkWord("ctrl read", 32'hA, word);
        axiRead(`TIMER1_BASE + `TIMER_COUNT_OFF, word, resp);
        checkResp("count read", respOkay, resp);
        checkWord("count read", 32'd0, word);
        axiWrite(16'h7F20, value, 4'hF, resp);
        checkResp("unmapped write", respDecErr, resp);
        axiRead(16'h1000, word, resp);
        checkResp("unmapped read", respDecErr, resp);
        axiRead(`TIMER0_BASE + 16'h2, word, resp);
        checkResp("non-word read", respDecErr, resp);
        axiWrite(`TIMER0_BASE + `TIMER_PRESET_OFF, ~value, 4'b0011, resp);
        checkResp("partial strobe", respSlvErr, resp);
        axiRead(`TIMER0_BASE + `TIMER_PRESET_OFF, word, resp);
        checkWord("partial strobe kept", value, word);
        axiWrite(`TIMER1_BASE + `TIMER_CTRL_OFF, 32'd0, 4'hF, resp);
    endtask

    task automatic testOneShot();
        logic [31:0] preset;
        logic [31:0] word;
        axiResp      resp;
        int          waited;
        preset = $random(seed) & 32'h3F;
        cp0Write(regSR, 32'h0000_0401);     // IE plus mask for timer0
        axiWrite(`TIMER0_BASE + `TIMER_PRESET_OFF, preset, 4'hF, resp);
        axiWrite(`TIMER0_BASE + `TIMER_CTRL_OFF, 32'h9, 4'hF, resp);  // enable, irq on
        waited = 0;
        while (!excReq && waited <= preset + 6) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!excReq) begin
            reportFailure("One-shot timer interrupt did not reach excReq in time");
        end
        @(negedge clk);
        cp0Read(regCause, word);
        checkCode("one-shot code", excInt, excCode'(word[`CAUSE_EXC_HI:`CAUSE_EXC_LO]));
        checkWord("one-shot IP", 32'h1, {26'd0, word[`CAUSE_IP_HI:`CAUSE_IP_LO]});
        axiRead(`TIMER0_BASE + `TIMER_COUNT_OFF, word, resp);
        checkWord("one-shot count", 32'd0, word);
        axiRead(`TIMER0_BASE + `TIMER_CTRL_OFF, word, resp);
        checkWord("one-shot ctrl", 32'h8, word);
        axiWrite(`TIMER0_BASE + `TIMER_CTRL_OFF, 32'd0, 4'hF, resp);  // drops the irq
        cp0Write(regSR, 32'd0);
        cp0Read(regCause, word);
        checkWord("one-shot IP cleared", 32'd0, {26'd0, word[`CAUSE_IP_HI:`CAUSE_IP_LO]});
    endtask

    task automatic testAutoReload();
        logic [31:0] preset;
        logic [31:0] word;
        axiResp      resp;
        int          waited;
        preset = 32'd16 + ($random(seed) & 32'h1F);
        cp0Write(regSR, 32'h0000_0801);     // IE plus mask for timer1
        axiWrite(`TIMER1_BASE + `TIMER_PRESET_OFF, preset, 4'hF, resp);
        axiWrite(`TIMER1_BASE + `TIMER_CTRL_OFF, 32'hB, 4'hF, resp);  // auto-reload
        for (int pulse = 0; pulse < 2; pulse++) begin
            @(negedge clk);
            cp0Addr = regCause;
            waited  = 0;
            while (!excReq && waited < 2 * preset + 20) begin
                @(negedge clk);
                waited = waited + 1;
            end
            if (!excReq) begin
                reportFailure("Auto-reload timer gave no interrupt in time");
            end
            @(negedge clk);
            #1;
            word = cp0RdData;               // IP latched on the pulse edge
            checkWord("reload IP", 32'h2, {26'd0, word[`CAUSE_IP_HI:`CAUSE_IP_LO]});
            checkCode("reload code", excInt, excCode'(word[`CAUSE_EXC_HI:`CAUSE_EXC_LO]));
            @(negedge clk);
            #1;
            word = cp0RdData;               // line gone after one cycle
            checkWord("reload IP pulse", 32'h0, {26'd0, word[`CAUSE_IP_HI:`CAUSE_IP_LO]});
            axiRead(`TIMER1_BASE + `TIMER_COUNT_OFF, word, resp);
            if (word > preset) begin
                reportFailure($sformatf("Error in reload count: expected at most %0d, actual %0d",
                                        preset, word));
            end
            pulseEret();
        end
        axiWrite(`TIMER1_BASE + `TIMER_CTRL_OFF, 32'd0, 4'hF, resp);
        cp0Write(regSR, 32'd0);
    endtask

    initial begin
        reset       = 1'b1;
        setFlags(6'b0);
        victimPc    = 32'd0;
        inDelaySlot = 1'b0;
        cp0Addr     = regSR;
        cp0WrData   = 32'd0;
        cp0WrEn     = 1'b0;
        eret        = 1'b0;
        extInt      = 4'd0;
        awvalid     = 1'b0;
        awaddr      = 16'd0;
        wvalid      = 1'b0;
        wdata       = 32'd0;
        wstrb       = 4'd0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = 16'd0;
        rready      = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        testCp0Regs();
        testExceptions();
        testInterrupts();
        testTimerBus();
        testOneShot();
        testAutoReload();
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
source/excPkg.sv
source/excPriority.sv
source/cp0Regs.sv
source/intervalTimer.sv
source/timerBus.sv
source/excUnit.sv
tb/excUnit_properties.sv
tb/excUnit_tb.sv
